//--- build.f
design/isa_pkg.sv
design/core_pkg.sv
design/instruction_memory.sv
design/fetch_issue_unit.sv
design/register_file.sv
design/execution_lane.sv
design/dual_issue_core.sv
sim/clock_gen.sv
sim/core_checker.sv
sim/tb_dual_issue_core.sv

//--- design/core_pkg.sv
package core_pkg;

  ////////////////////////////////////////////////////////////
  // core sizes
  ////////////////////////////////////////////////////////////

  localparam int data_width      = 32;
  localparam int num_regs        = 32;
  localparam int reg_addr_width  = 5;
  localparam int num_lanes       = 2;
  localparam int imem_depth      = 64;
  localparam int imem_addr_width = 6;
  // one bit more than the address so a full store can be counted
  localparam int prog_len_width  = 7;

  ////////////////////////////////////////////////////////////
  // pipeline records
  ////////////////////////////////////////////////////////////

  // one decoded instruction waiting in the issue register
  typedef struct packed {
    logic                              valid;
    isa_pkg::alu_op_e                  alu_op;
    logic [reg_addr_width-1:0]         dst;
    logic [reg_addr_width-1:0]         src_a;
    logic [reg_addr_width-1:0]         src_b;
    logic                              use_imm;
    logic [data_width-1:0]             imm;
    logic [isa_pkg::shamt_width-1:0]   shamt;
  } issue_slot_t;

  // result leaving a lane, also the register file write request
  typedef struct packed {
    logic                      valid;
    logic [reg_addr_width-1:0] dst;
    logic [data_width-1:0]     data;
  } wb_rec_t;

  typedef wb_rec_t [num_lanes-1:0] wb_array_t;

endpackage

//--- design/dual_issue_core.sv
module dual_issue_core (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 prog_we,
  input  logic [core_pkg::imem_addr_width-1:0] prog_addr,
  input  isa_pkg::inst_u                       prog_data,
  input  logic [core_pkg::prog_len_width-1:0]  prog_len,
  input  logic                                 start,
  output logic                                 busy,
  output wire core_pkg::wb_array_t             wb
);

  logic [core_pkg::imem_addr_width-1:0]             fetch_addr;
  isa_pkg::inst_u [core_pkg::num_lanes-1:0]         fetch_word;
  core_pkg::issue_slot_t [core_pkg::num_lanes-1:0]  issue;
  logic [core_pkg::num_lanes-1:0][core_pkg::data_width-1:0] operand_a;
  logic [core_pkg::num_lanes-1:0][core_pkg::data_width-1:0] operand_b;

  ////////////////////////////////////////////////////////////
  // fetch and issue
  ////////////////////////////////////////////////////////////

  instruction_memory u_imem (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_addr   (fetch_addr),
    .rd_word   (fetch_word)
  );

  fetch_issue_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .prog_len   (prog_len),
    .fetch_word (fetch_word),
    .fetch_addr (fetch_addr),
    .issue      (issue),
    .busy       (busy)
  );

  // operands are read for the slots sitting in the issue register
  register_file u_regfile (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .wb        (wb),
    .operand_a (operand_a),
    .operand_b (operand_b)
  );

  ////////////////////////////////////////////////////////////
  // execution lanes, lane 0 holds the older instruction
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < core_pkg::num_lanes; i++) begin : g_lane
    execution_lane u_lane (
      .clk       (clk),
      .rst       (rst),
      .slot      (issue[i]),
      .operand_a (operand_a[i]),
      .operand_b (operand_b[i]),
      .wb        (wb[i])
    );
  end

endmodule

//--- design/execution_lane.sv
module execution_lane (
  input  logic                            clk,
  input  logic                            rst,
  input  core_pkg::issue_slot_t           slot,
  input  logic [core_pkg::data_width-1:0] operand_a,
  input  logic [core_pkg::data_width-1:0] operand_b,
  output core_pkg::wb_rec_t               wb
);

  logic [core_pkg::data_width-1:0] b_val;
  logic [core_pkg::data_width-1:0] result;
  logic                            less;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////

  // immediate is already extended by decode
  assign b_val = slot.use_imm ? slot.imm : operand_b;

  assign less = $signed(operand_a) < $signed(b_val);

  always_comb begin
    case (slot.alu_op)
      isa_pkg::alu_add: result = operand_a + b_val;
      isa_pkg::alu_sub: result = operand_a - b_val;
      isa_pkg::alu_and: result = operand_a & b_val;
      isa_pkg::alu_or:  result = operand_a | b_val;
      isa_pkg::alu_xor: result = operand_a ^ b_val;
      isa_pkg::alu_slt: begin
        result = {{(core_pkg::data_width-1){1'b0}}, less};
      end
      // shifts move rt, the amount comes from the word itself
      isa_pkg::alu_sll: result = b_val << slot.shamt;
      isa_pkg::alu_srl: result = b_val >> slot.shamt;
      // upper half was placed by decode
      isa_pkg::alu_lui: result = b_val;
      default:          result = operand_a + b_val;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // writeback register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= slot.valid;
      wb.dst   <= slot.dst;
      wb.data  <= result;
    end
  end

endmodule

//--- design/fetch_issue_unit.sv
module fetch_issue_unit (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic                                        start,
  input  logic [core_pkg::prog_len_width-1:0]         prog_len,
  input  isa_pkg::inst_u [core_pkg::num_lanes-1:0]    fetch_word,
  output logic [core_pkg::imem_addr_width-1:0]        fetch_addr,
  output core_pkg::issue_slot_t [core_pkg::num_lanes-1:0] issue,
  output logic                                        busy
);

  logic [core_pkg::prog_len_width-1:0] pc;
  logic [core_pkg::prog_len_width-1:0] len_q;
  logic [core_pkg::prog_len_width-1:0] step;
  logic                                running;
  logic                                wb_pending;
  logic                                have_one;
  logic                                have_two;
  logic                                pair_dep;
  core_pkg::issue_slot_t [core_pkg::num_lanes-1:0] slot_d;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  function automatic core_pkg::issue_slot_t decode_word(input isa_pkg::inst_u w);
    core_pkg::issue_slot_t s;
    s        = '0;
    s.alu_op = isa_pkg::alu_add;
    s.src_a  = w.r.rs;
    s.src_b  = w.r.rt;
    s.shamt  = w.r.shamt;
    case (w.r.opcode)
      isa_pkg::op_rtype: begin
        s.dst = w.r.rd;
        case (w.r.funct)
          isa_pkg::fn_add: s.alu_op = isa_pkg::alu_add;
          isa_pkg::fn_sub: s.alu_op = isa_pkg::alu_sub;
          isa_pkg::fn_and: s.alu_op = isa_pkg::alu_and;
          isa_pkg::fn_or:  s.alu_op = isa_pkg::alu_or;
          isa_pkg::fn_xor: s.alu_op = isa_pkg::alu_xor;
          isa_pkg::fn_slt: s.alu_op = isa_pkg::alu_slt;
          isa_pkg::fn_sll: s.alu_op = isa_pkg::alu_sll;
          isa_pkg::fn_srl: s.alu_op = isa_pkg::alu_srl;
          // unknown funct becomes a harmless add to r0
          default:         s.dst = '0;
        endcase
      end
      isa_pkg::op_addi: begin
        s.dst     = w.i.rt;
        s.use_imm = 1'b1;
        s.imm     = {{(core_pkg::data_width-isa_pkg::imm_width){w.i.imm[isa_pkg::imm_width-1]}},
                     w.i.imm};
      end
      isa_pkg::op_andi: begin
        s.alu_op  = isa_pkg::alu_and;
        s.dst     = w.i.rt;
        s.use_imm = 1'b1;
        s.imm     = {{(core_pkg::data_width-isa_pkg::imm_width){1'b0}}, w.i.imm};
      end
      isa_pkg::op_ori: begin
        s.alu_op  = isa_pkg::alu_or;
        s.dst     = w.i.rt;
        s.use_imm = 1'b1;
        s.imm     = {{(core_pkg::data_width-isa_pkg::imm_width){1'b0}}, w.i.imm};
      end
      isa_pkg::op_lui: begin
        s.alu_op  = isa_pkg::alu_lui;
        s.dst     = w.i.rt;
        s.use_imm = 1'b1;
        s.imm     = {w.i.imm, {(core_pkg::data_width-isa_pkg::imm_width){1'b0}}};
      end
      default: s.dst = '0;
    endcase
    return s;
  endfunction

  ////////////////////////////////////////////////////////////
  // pair check and issue select
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < core_pkg::num_lanes; i++) begin
      slot_d[i] = decode_word(fetch_word[i]);
    end
    have_one = pc < len_q;
    have_two = (pc + 1'b1) < len_q;
    // younger word reads rs always, rt only in register format
    pair_dep = have_two && (slot_d[0].dst != '0) &&
               ((slot_d[1].src_a == slot_d[0].dst) ||
                ((fetch_word[1].r.opcode == isa_pkg::op_rtype) &&
                 (slot_d[1].src_b == slot_d[0].dst)));
    slot_d[0].valid = running && have_one;
    slot_d[1].valid = running && have_two && !pair_dep;
    if (slot_d[1].valid) begin
      step = 2;
    end else if (slot_d[0].valid) begin
      step = 1;
    end else begin
      step = 0;
    end
  end

  assign fetch_addr = pc[core_pkg::imem_addr_width-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      pc         <= '0;
      len_q      <= '0;
      running    <= 1'b0;
      wb_pending <= 1'b0;
      for (int i = 0; i < core_pkg::num_lanes; i++) begin
        issue[i].valid <= 1'b0;
      end
    end else begin
      issue      <= slot_d;
      // lane 0 is valid whenever anything issued
      wb_pending <= issue[0].valid;
      if (start) begin
        pc      <= '0;
        len_q   <= prog_len;
        running <= 1'b1;
      end else if (running) begin
        pc      <= pc + step;
        running <= (pc + step) < len_q;
      end
    end
  end

  // held until the last record has left the writeback stage
  assign busy = running || issue[0].valid || wb_pending;

endmodule

//--- design/instruction_memory.sv
module instruction_memory (
  input  logic                                  clk,
  input  logic                                  prog_we,
  input  logic [core_pkg::imem_addr_width-1:0]  prog_addr,
  input  isa_pkg::inst_u                        prog_data,
  input  logic [core_pkg::imem_addr_width-1:0]  rd_addr,
  output isa_pkg::inst_u [core_pkg::num_lanes-1:0] rd_word
);

  logic [isa_pkg::inst_width-1:0] mem [core_pkg::imem_depth];

  // per-lane read address, wraps at the end of the store
  logic [core_pkg::num_lanes-1:0][core_pkg::imem_addr_width-1:0] rd_idx;

  // program load port
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // lane i sees the word at rd_addr + i
  always_comb begin
    for (int i = 0; i < core_pkg::num_lanes; i++) begin
      rd_idx[i]  = rd_addr + core_pkg::imem_addr_width'(i);
      rd_word[i] = mem[rd_idx[i]];
    end
  end

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word layout
  ////////////////////////////////////////////////////////////

  localparam int inst_width      = 32;
  localparam int opcode_width    = 6;
  localparam int reg_field_width = 5;
  localparam int shamt_width     = 5;
  localparam int funct_width     = 6;
  localparam int imm_width       = 16;

  // register format: add, sub, and, or, xor, slt, sll, srl
  typedef struct packed {
    logic [opcode_width-1:0]    opcode;
    logic [reg_field_width-1:0] rs;
    logic [reg_field_width-1:0] rt;
    logic [reg_field_width-1:0] rd;
    logic [shamt_width-1:0]     shamt;
    logic [funct_width-1:0]     funct;
  } r_format_t;

  // immediate format: addi, andi, ori, lui
  typedef struct packed {
    logic [opcode_width-1:0]    opcode;
    logic [reg_field_width-1:0] rs;
    logic [reg_field_width-1:0] rt;
    logic [imm_width-1:0]       imm;
  } i_format_t;

  // opcode sits in the same bits in both views
  typedef union packed {
    r_format_t r;
    i_format_t i;
  } inst_u;

  ////////////////////////////////////////////////////////////
  // encodings (MIPS values)
  ////////////////////////////////////////////////////////////

  localparam logic [opcode_width-1:0] op_rtype = 6'h00;
  localparam logic [opcode_width-1:0] op_addi  = 6'h08;
  localparam logic [opcode_width-1:0] op_andi  = 6'h0c;
  localparam logic [opcode_width-1:0] op_ori   = 6'h0d;
  localparam logic [opcode_width-1:0] op_lui   = 6'h0f;

  localparam logic [funct_width-1:0] fn_sll = 6'h00;
  localparam logic [funct_width-1:0] fn_srl = 6'h02;
  localparam logic [funct_width-1:0] fn_add = 6'h20;
  localparam logic [funct_width-1:0] fn_sub = 6'h22;
  localparam logic [funct_width-1:0] fn_and = 6'h24;
  localparam logic [funct_width-1:0] fn_or  = 6'h25;
  localparam logic [funct_width-1:0] fn_xor = 6'h26;
  localparam logic [funct_width-1:0] fn_slt = 6'h2a;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_e;

endpackage

//--- design/register_file.sv
module register_file (
  input  logic                                                clk,
  input  logic                                                rst,
  input  core_pkg::issue_slot_t [core_pkg::num_lanes-1:0]     issue,
  input  core_pkg::wb_array_t                                 wb,
  output logic [core_pkg::num_lanes-1:0][core_pkg::data_width-1:0] operand_a,
  output logic [core_pkg::num_lanes-1:0][core_pkg::data_width-1:0] operand_b
);

  logic [core_pkg::data_width-1:0] regs [core_pkg::num_regs];

  // stored value, overridden by a matching writeback record
  function automatic logic [core_pkg::data_width-1:0] read_src(
    input logic [core_pkg::reg_addr_width-1:0] addr
  );
    logic [core_pkg::data_width-1:0] value;
    value = regs[addr];
    // later lanes win, so lane 1 beats lane 0
    for (int l = 0; l < core_pkg::num_lanes; l++) begin
      if (wb[l].valid && (wb[l].dst == addr)) begin
        value = wb[l].data;
      end
    end
    if (addr == '0) begin
      value = '0;
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < core_pkg::num_lanes; i++) begin
      operand_a[i] = read_src(issue[i].src_a);
      operand_b[i] = read_src(issue[i].src_b);
    end
  end

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < core_pkg::num_regs; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // same register from both lanes: the last write (lane 1) sticks
      for (int l = 0; l < core_pkg::num_lanes; l++) begin
        if (wb[l].valid && (wb[l].dst != '0)) begin
          regs[wb[l].dst] <= wb[l].data;
        end
      end
    end
  end

endmodule

//--- sim/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int half_period = 50;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // reset held over three rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

//--- sim/core_checker.sv
module core_checker (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       busy,
  input  core_pkg::wb_array_t                        wb,
  input  isa_pkg::inst_u [core_pkg::imem_depth-1:0]  prog,
  input  logic [core_pkg::prog_len_width-1:0]        prog_len,
  input  logic                                       test_begin,
  input  logic                                       test_done,
  output int                                         passed,
  output int                                         failed,
  output int                                         errors
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [core_pkg::data_width-1:0] model_regs [core_pkg::num_regs];
  // one entry per cycle that shows records
  // lane 1 is valid only for a full pair
  core_pkg::wb_array_t exp_q[$];
  int   test_errs;
  int   test_num;
  int   records;
  logic active;
  logic seen;

  initial begin
    passed   = 0;
    failed   = 0;
    errors   = 0;
    test_num = 0;
    active   = 1'b0;
    seen     = 1'b0;
  end

  //////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////

  function automatic core_pkg::wb_rec_t model_exec(input isa_pkg::inst_u w);
    core_pkg::wb_rec_t               rec;
    logic [core_pkg::data_width-1:0] a;
    logic [core_pkg::data_width-1:0] b;
    logic [core_pkg::data_width-1:0] sext;
    logic [core_pkg::data_width-1:0] zext;
    a         = model_regs[w.r.rs];
    b         = model_regs[w.r.rt];
    sext      = core_pkg::data_width'($signed(w.i.imm));
    zext      = core_pkg::data_width'(w.i.imm);
    rec.valid = 1'b1;
    rec.dst   = w.i.rt;
    rec.data  = '0;
    case (w.r.opcode)
      isa_pkg::op_rtype: begin
        rec.dst = w.r.rd;
        case (w.r.funct)
          isa_pkg::fn_add: rec.data = a + b;
          isa_pkg::fn_sub: rec.data = a - b;
          isa_pkg::fn_and: rec.data = a & b;
          isa_pkg::fn_or:  rec.data = a | b;
          isa_pkg::fn_xor: rec.data = a ^ b;
          isa_pkg::fn_slt: rec.data = ($signed(a) < $signed(b)) ? 1 : 0;
          isa_pkg::fn_sll: rec.data = b << w.r.shamt;
          isa_pkg::fn_srl: rec.data = b >> w.r.shamt;
          default: begin
            rec.dst  = '0;
            rec.data = a + b;
          end
        endcase
      end
      isa_pkg::op_addi: rec.data = a + sext;
      isa_pkg::op_andi: rec.data = a & zext;
      isa_pkg::op_ori:  rec.data = a | zext;
      isa_pkg::op_lui:  rec.data = {w.i.imm, 16'h0000};
      default: begin
        rec.dst  = '0;
        rec.data = a + b;
      end
    endcase
    if (rec.dst != '0) begin
      model_regs[rec.dst] = rec.data;
    end
    return rec;
  endfunction

  // younger word reads rs always and rt only in register format
  function automatic logic reads_reg(input isa_pkg::inst_u w,
                                     input logic [core_pkg::reg_addr_width-1:0] r);
    return (r != '0) &&
           ((w.r.rs == r) || ((w.r.opcode == isa_pkg::op_rtype) && (w.r.rt == r)));
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    test_errs++;
    errors++;
  endtask

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
      test_errs++;
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////
  // test bookkeeping on the rising edge
  //////////////////////////////////////////////////////////////

  always @(posedge clk) begin : control
    int                  i;
    core_pkg::wb_array_t e;
    if (rst) begin
      for (int r = 0; r < core_pkg::num_regs; r++) begin
        model_regs[r] = '0;
      end
      exp_q.delete();
      active = 1'b0;
    end else if (test_begin) begin
      i = 0;
      while (i < prog_len) begin
        e    = '0;
        e[0] = model_exec(prog[i]);
        if ((i + 1 < prog_len) && !reads_reg(prog[i + 1], e[0].dst)) begin
          e[1] = model_exec(prog[i + 1]);
          i    = i + 2;
        end else begin
          i = i + 1;
        end
        exp_q.push_back(e);
      end
      test_errs = 0;
      records   = 0;
      seen      = 1'b0;
      active    = 1'b1;
    end else if (test_done) begin
      if (exp_q.size() != 0) begin
        report_error($sformatf("%0d result cycles never appeared", exp_q.size()));
      end
      $display("test %0d %s: %0d words, %0d records, %0d errors", test_num,
               (test_errs == 0) ? "passed" : "failed", prog_len, records, test_errs);
      if (test_errs == 0) begin
        passed++;
      end else begin
        failed++;
      end
      test_num++;
      exp_q.delete();
      active = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////
  // writeback stream check on the falling edge
  //////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    core_pkg::wb_array_t e;
    if (rst === 1'b0) begin
      if (!active && busy) begin
        report_error("busy is high with no program running");
      end
      if (wb[0].valid || wb[1].valid) begin
        if (!busy) begin
          report_error("writeback record shown while busy is low");
        end
        if (exp_q.size() == 0) begin
          report_error("extra writeback record where none was expected");
        end else begin
          e    = exp_q.pop_front();
          seen = 1'b1;
          check_field("wb[0].valid", 1, wb[0].valid);
          check_field("wb[0].dst", e[0].dst, wb[0].dst);
          check_field("wb[0].data", e[0].data, wb[0].data);
          // lane 1 valid tells whether the pair was split
          check_field("wb[1].valid", e[1].valid, wb[1].valid);
          if (e[1].valid && wb[1].valid) begin
            check_field("wb[1].dst", e[1].dst, wb[1].dst);
            check_field("wb[1].data", e[1].data, wb[1].data);
          end
          records += 1 + e[1].valid;
        end
      end else if (active && seen && (exp_q.size() != 0)) begin
        report_error("gap in the writeback stream before the program finished");
      end else if (active && seen && busy) begin
        report_error("busy still high in the cycle after the last record");
        seen = 1'b0;
      end
    end
  end

endmodule

//--- sim/tb_dual_issue_core.sv
module tb_dual_issue_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tests = 8;
  localparam int period_ns = 100;

  logic                                      clk;
  logic                                      rst;
  logic                                      prog_we;
  logic [core_pkg::imem_addr_width-1:0]      prog_addr;
  isa_pkg::inst_u                            prog_data;
  logic [core_pkg::prog_len_width-1:0]       prog_len;
  logic                                      start;
  logic                                      busy;
  core_pkg::wb_array_t                       wb;
  isa_pkg::inst_u [core_pkg::imem_depth-1:0] prog;
  logic                                      test_begin;
  logic                                      test_done;
  int                                        passed;
  int                                        failed;
  int                                        errors;
  int                                        prog_lens [num_tests];
  int                                        total_len;
  int                                        limit_cycles;

  clock_gen u_clock (
    .clk (clk),
    .rst (rst)
  );

  dual_issue_core UUT (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .prog_len  (prog_len),
    .start     (start),
    .busy      (busy),
    .wb        (wb)
  );

  core_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .wb         (wb),
    .prog       (prog),
    .prog_len   (prog_len),
    .test_begin (test_begin),
    .test_done  (test_done),
    .passed     (passed),
    .failed     (failed),
    .errors     (errors)
  );

  //////////////////////////////////////////////////////////////
  // program generation
  //////////////////////////////////////////////////////////////

  // a small pool makes pair dependencies and r0 writes common
  function automatic logic [core_pkg::reg_addr_width-1:0] pick_reg(input int pool);
    return core_pkg::reg_addr_width'($urandom_range(pool - 1, 0));
  endfunction

  function automatic isa_pkg::inst_u random_word(input int pool);
    isa_pkg::inst_u w;
    int             kind;
    w      = $urandom;
    kind   = $urandom_range(11, 0);
    w.r.rs = pick_reg(pool);
    w.r.rt = pick_reg(pool);
    if (kind < 8) begin
      w.r.opcode = isa_pkg::op_rtype;
      w.r.rd     = pick_reg(pool);
      case (kind)
        0:       w.r.funct = isa_pkg::fn_add;
        1:       w.r.funct = isa_pkg::fn_sub;
        2:       w.r.funct = isa_pkg::fn_and;
        3:       w.r.funct = isa_pkg::fn_or;
        4:       w.r.funct = isa_pkg::fn_xor;
        5:       w.r.funct = isa_pkg::fn_slt;
        6:       w.r.funct = isa_pkg::fn_sll;
        default: w.r.funct = isa_pkg::fn_srl;
      endcase
    end else begin
      case (kind)
        8:       w.i.opcode = isa_pkg::op_addi;
        9:       w.i.opcode = isa_pkg::op_andi;
        10:      w.i.opcode = isa_pkg::op_ori;
        default: w.i.opcode = isa_pkg::op_lui;
      endcase
    end
    return w;
  endfunction

  task automatic run_program(input int len, input int pool);
    for (int a = 0; a < len; a++) begin
      prog[a] = random_word(pool);
    end
    for (int a = 0; a < len; a++) begin
      prog_we   = 1'b1;
      prog_addr = core_pkg::imem_addr_width'(a);
      prog_data = prog[a];
      @(negedge clk);
    end
    prog_we    = 1'b0;
    prog_len   = core_pkg::prog_len_width'(len);
    start      = 1'b1;
    test_begin = 1'b1;
    @(negedge clk);
    start      = 1'b0;
    test_begin = 1'b0;
    while (busy) begin
      @(negedge clk);
    end
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////
  // stimulus and summary
  //////////////////////////////////////////////////////////////

  initial begin
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    prog_len   = '0;
    start      = 1'b0;
    test_begin = 1'b0;
    test_done  = 1'b0;
    prog       = '0;
    void'($urandom(32'hf6e0));
    total_len = 0;
    // odd tests get odd lengths
    for (int t = 0; t < num_tests; t++) begin
      prog_lens[t] = 2 * $urandom_range(12, 1) - (t % 2);
      total_len += prog_lens[t];
    end
    // each word costs one load cycle and at most one issue cycle
    // plus a fixed overhead per test
    limit_cycles = 2 * total_len + 10 * num_tests + 20;
    fork
      begin
        #(limit_cycles * period_ns);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
      end
    join_none
    do begin
      @(negedge clk);
    end while (rst !== 1'b0);
    // idle cycles where busy and every record must stay low
    repeat (5) @(negedge clk);
    for (int t = 0; t < num_tests; t++) begin
      run_program(prog_lens[t], (t % 3 == 1) ? 32 : 4);
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if ((failed == 0) && (errors == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
